/* compile.f */
fxp_pkg.sv
plot_pkg.sv
fixed_point_alu.sv
rpn_queue.sv
stack_machine.sv
plot_eval_top.sv
tb_plot_eval.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_plot_eval -o sim_plot_eval
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_plot_eval > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0

/* tb_plot_eval.sv */
`timescale 1ns/1ps

module tb_plot_eval;

    // 12 tests x 64 tokens x 40 cycles at 40 ns
    localparam time WATCHDOG_NS = 12 * 64 * 40 * 40;
    localparam int  ACK_LIMIT   = 4000;

    logic                          clk;
    logic                          rst_n;
    logic                          tok_clear;
    logic                          tok_wr;
    plot_pkg::token_t              tok_data;
    logic [plot_pkg::QLEN_W-1:0]   tok_count;
    logic                          eval_req;
    logic [plot_pkg::X_W-1:0]      x_in;
    logic                          eval_ack;
    logic [plot_pkg::Y_W-1:0]      y_out;

    // formula currently held in the queue
    plot_pkg::token_t formula [$];
    plot_pkg::token_t none [$];

    plot_eval_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .tok_clear (tok_clear),
        .tok_wr    (tok_wr),
        .tok_data  (tok_data),
        .tok_count (tok_count),
        .eval_req  (eval_req),
        .x_in      (x_in),
        .eval_ack  (eval_ack),
        .y_out     (y_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $fatal(1, "watchdog");
    end

    task automatic report_mismatch(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "mismatch");
    endtask

    task automatic check_y(input logic [plot_pkg::Y_W-1:0] got,
                           input logic [plot_pkg::Y_W-1:0] exp,
                           input logic [plot_pkg::X_W-1:0] x);
        if (got !== exp) begin
            report_mismatch($sformatf("y_out for x=%0d is %0d, expected %0d", x, got, exp));
        end
    endtask

    task automatic check_count(input logic [plot_pkg::QLEN_W-1:0] got,
                               input logic [plot_pkg::QLEN_W-1:0] exp);
        if (got !== exp) begin
            report_mismatch($sformatf("tok_count is %0d, expected %0d", got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    function automatic fxp_pkg::fxp_t to_fixed(input int n);
        return fxp_pkg::fxp_t'(n << fxp_pkg::FRAC_W);
    endfunction

    // arithmetic rules on wide integers, wrapped back to 20 bits
    function automatic fxp_pkg::fxp_t alu_model(input fxp_pkg::alu_op_e op,
                                                input fxp_pkg::fxp_t a,
                                                input fxp_pkg::fxp_t b);
        longint la;
        longint lb;
        longint r;
        longint mag;
        int     n;
        int     i;
        la = a;
        lb = b;
        case (op)
            fxp_pkg::OP_ADD: r = la + lb;
            fxp_pkg::OP_SUB: r = la - lb;
            fxp_pkg::OP_MUL: r = (la * lb) >>> fxp_pkg::FRAC_W;
            fxp_pkg::OP_DIV: begin
                if (lb == 0) begin
                    r = (la >= 0) ? fxp_pkg::FXP_MAX : fxp_pkg::FXP_MIN;
                end else begin
                    mag = ((la < 0 ? -la : la) << fxp_pkg::FRAC_W) / (lb < 0 ? -lb : lb);
                    r   = ((la < 0) != (lb < 0)) ? -mag : mag;
                end
            end
            fxp_pkg::OP_POW: begin
                n = int'(lb >>> fxp_pkg::FRAC_W);
                if (n > fxp_pkg::POW_MAX_EXP) n = fxp_pkg::POW_MAX_EXP;
                r = (n <= 0) ? fxp_pkg::FXP_ONE : la;
                for (i = 1; i < n; i++) begin
                    r = longint'(fxp_pkg::fxp_t'((r * la) >>> fxp_pkg::FRAC_W));
                end
            end
            default: r = 0;
        endcase
        return fxp_pkg::fxp_t'(r);
    endfunction

    function automatic logic [plot_pkg::Y_W-1:0] model_y(input plot_pkg::token_t toks [$],
                                                         input logic [plot_pkg::X_W-1:0] x);
        fxp_pkg::fxp_t st [$];
        fxp_pkg::fxp_t xv;
        fxp_pkg::fxp_t a;
        fxp_pkg::fxp_t b;
        fxp_pkg::fxp_t v;
        xv = alu_model(fxp_pkg::OP_SUB, to_fixed(int'(x)), to_fixed(plot_pkg::H_PIXELS / 2));
        xv = alu_model(fxp_pkg::OP_DIV, xv, to_fixed(plot_pkg::PLOT_SCALE));
        foreach (toks[i]) begin
            if (!toks[i][plot_pkg::TOK_W-1]) begin
                st.push_back(fxp_pkg::fxp_t'(toks[i][fxp_pkg::NUM_W-1:0]));
            end else if (toks[i][2:0] == 3'(plot_pkg::TOK_VAR)) begin
                st.push_back(xv);
            end else begin
                b = st.pop_back();
                a = st.pop_back();
                st.push_back(alu_model(fxp_pkg::alu_op_e'(toks[i][2:0]), a, b));
            end
        end
        v = alu_model(fxp_pkg::OP_MUL, st[0], to_fixed(plot_pkg::PLOT_SCALE));
        v = alu_model(fxp_pkg::OP_SUB, to_fixed(plot_pkg::V_PIXELS / 2), v);
        return v[fxp_pkg::FRAC_W +: plot_pkg::Y_W];
    endfunction

    function automatic plot_pkg::token_t const_token(input int raw);
        return {1'b0, fxp_pkg::fxp_t'(raw)};
    endfunction

    function automatic plot_pkg::token_t op_token(input fxp_pkg::alu_op_e o);
        return {1'b1, {(plot_pkg::TOK_W-4){1'b0}}, o};
    endfunction

    function automatic plot_pkg::token_t var_token();
        return {1'b1, {(plot_pkg::TOK_W-4){1'b0}}, 3'(plot_pkg::TOK_VAR)};
    endfunction

    task automatic load_formula(input plot_pkg::token_t toks [$]);
        logic [plot_pkg::QLEN_W-1:0] exp_count;
        exp_count = (toks.size() > plot_pkg::QUEUE_SIZE) ? plot_pkg::QUEUE_SIZE : toks.size();
        formula = toks;
        @(posedge clk);
        tok_clear <= 1'b1;
        @(posedge clk);
        tok_clear <= 1'b0;
        foreach (toks[i]) begin
            tok_wr   <= 1'b1;
            tok_data <= toks[i];
            @(posedge clk);
        end
        tok_wr <= 1'b0;
        @(posedge clk);
        check_count(tok_count, exp_count);
    endtask

    task automatic wait_ack();
        int cycles;
        cycles = 0;
        while (eval_ack !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > ACK_LIMIT) begin
                $display("eval_ack never rose within %0d cycles of eval_req", ACK_LIMIT);
                $display("Test failed");
                $fatal(1, "handshake stuck");
            end
        end
    endtask

    // full four-phase cycle, ack must outlive req by one cycle
    task automatic evaluate(input logic [plot_pkg::X_W-1:0] x,
                            output logic [plot_pkg::Y_W-1:0] y);
        @(posedge clk);
        x_in     <= x;
        eval_req <= 1'b1;
        wait_ack();
        y = y_out;
        repeat (2) begin
            @(posedge clk);
            check_bit(eval_ack, 1'b1, "eval_ack while eval_req high");
        end
        eval_req <= 1'b0;
        @(posedge clk);
        check_bit(eval_ack, 1'b1, "eval_ack in the cycle eval_req falls");
        @(posedge clk);
        check_bit(eval_ack, 1'b0, "eval_ack after eval_req low");
    endtask

    task automatic check_column(input logic [plot_pkg::X_W-1:0] x);
        logic [plot_pkg::Y_W-1:0] y;
        evaluate(x, y);
        check_y(y, model_y(formula, x), x);
    endtask

    task automatic run_formula(input plot_pkg::token_t toks [$], input int n);
        load_formula(toks);
        repeat (n) check_column($urandom % plot_pkg::H_PIXELS);
    endtask

    task automatic reset_and_queue_checks();
        plot_pkg::token_t many [$];
        int               i;
        check_bit(eval_ack, 1'b0, "eval_ack after reset");
        check_count(tok_count, '0);
        load_formula('{var_token(), const_token(256), op_token(fxp_pkg::OP_ADD)});
        load_formula(none);
        // writes past a full queue are dropped
        for (i = 0; i < plot_pkg::QUEUE_SIZE + 6; i++) begin
            many.push_back(const_token(i));
        end
        load_formula(many);
        load_formula(none);
    endtask

    task automatic identity_formula();
        load_formula('{var_token()});
        check_column(0);
        check_column(319);
        check_column(320);
        check_column(639);
        repeat (10) check_column($urandom % plot_pkg::H_PIXELS);
    endtask

    task automatic arith_formulas();
        run_formula('{var_token(), const_token(384), op_token(fxp_pkg::OP_ADD)}, 4);
        run_formula('{var_token(), const_token(-576), op_token(fxp_pkg::OP_SUB)}, 4);
        run_formula('{var_token(), const_token(192), op_token(fxp_pkg::OP_MUL)}, 4);
        // x*x*0.5 - 3
        run_formula('{var_token(), var_token(), op_token(fxp_pkg::OP_MUL), const_token(128),
                      op_token(fxp_pkg::OP_MUL), const_token(768), op_token(fxp_pkg::OP_SUB)}, 4);
        // 2*(x - 1.5) - x
        run_formula('{const_token(512), var_token(), const_token(-384), op_token(fxp_pkg::OP_ADD),
                      op_token(fxp_pkg::OP_MUL), var_token(), op_token(fxp_pkg::OP_SUB)}, 4);
    endtask

    task automatic divide_formulas();
        run_formula('{var_token(), const_token(512), op_token(fxp_pkg::OP_DIV)}, 3);
        run_formula('{var_token(), const_token(-192), op_token(fxp_pkg::OP_DIV)}, 3);
        // x = 320 divides by zero
        run_formula('{const_token(-768), var_token(), op_token(fxp_pkg::OP_DIV)}, 2);
        check_column(320);
        run_formula('{const_token(256), var_token(), op_token(fxp_pkg::OP_DIV)}, 2);
        check_column(320);
        run_formula('{var_token(), const_token(768), op_token(fxp_pkg::OP_ADD), const_token(128),
                      var_token(), op_token(fxp_pkg::OP_MUL), op_token(fxp_pkg::OP_DIV)}, 3);
    endtask

    task automatic power_formulas();
        run_formula('{var_token(), const_token(0), op_token(fxp_pkg::OP_POW)}, 3);
        run_formula('{var_token(), const_token(256), op_token(fxp_pkg::OP_POW)}, 3);
        run_formula('{var_token(), const_token(768), op_token(fxp_pkg::OP_POW)}, 3);
        run_formula('{var_token(), const_token(-512), op_token(fxp_pkg::OP_POW)}, 3);
        run_formula('{var_token(), const_token(640), op_token(fxp_pkg::OP_POW)}, 3);
        // above the clamp
        run_formula('{var_token(), const_token(5120), op_token(fxp_pkg::OP_POW)}, 3);
    endtask

    task automatic reload_between_columns();
        load_formula('{var_token(), const_token(512), op_token(fxp_pkg::OP_MUL)});
        check_column(400);
        load_formula('{var_token()});
        check_column(400);
        load_formula('{var_token(), const_token(1280), op_token(fxp_pkg::OP_ADD)});
        check_column(400);
        check_column(100);
    endtask

    initial begin
        void'($urandom(11));
        rst_n     <= 1'b0;
        tok_clear <= 1'b0;
        tok_wr    <= 1'b0;
        tok_data  <= '0;
        eval_req  <= 1'b0;
        x_in      <= '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        reset_and_queue_checks();
        identity_formula();
        arith_formulas();
        divide_formulas();
        power_formulas();
        reload_between_columns();
        $display("Test passed");
        $finish;
    end

endmodule

/* plot_eval_top.sv */
`timescale 1ns/1ps

module plot_eval_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          tok_clear,
    input  logic                          tok_wr,
    input  plot_pkg::token_t              tok_data,
    output logic [plot_pkg::QLEN_W-1:0]   tok_count,
    input  logic                          eval_req,
    input  logic [plot_pkg::X_W-1:0]      x_in,
    output logic                          eval_ack,
    output logic [plot_pkg::Y_W-1:0]      y_out
);

    logic                          get_req;
    logic [plot_pkg::QIDX_W-1:0]   get_index;
    logic                          get_ack;
    plot_pkg::token_t              get_data;
    logic                          alu_req;
    fxp_pkg::alu_op_e              alu_op;
    fxp_pkg::fxp_t                 alu_a;
    fxp_pkg::fxp_t                 alu_b;
    logic                          alu_ack;
    fxp_pkg::fxp_t                 alu_result;

    rpn_queue i_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .tok_clear (tok_clear),
        .tok_wr    (tok_wr),
        .tok_data  (tok_data),
        .tok_count (tok_count),
        .get_req   (get_req),
        .get_index (get_index),
        .get_ack   (get_ack),
        .get_data  (get_data)
    );

    stack_machine i_machine (
        .clk        (clk),
        .rst_n      (rst_n),
        .eval_req   (eval_req),
        .x_in       (x_in),
        .eval_ack   (eval_ack),
        .y_out      (y_out),
        .tok_count  (tok_count),
        .get_req    (get_req),
        .get_index  (get_index),
        .get_ack    (get_ack),
        .get_data   (get_data),
        .alu_req    (alu_req),
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_ack    (alu_ack),
        .alu_result (alu_result)
    );

    fixed_point_alu i_alu (
        .clk        (clk),
        .rst_n      (rst_n),
        .alu_req    (alu_req),
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_ack    (alu_ack),
        .alu_result (alu_result)
    );

endmodule

/* stack_machine.sv */
`timescale 1ns/1ps

module stack_machine (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          eval_req,
    input  logic [plot_pkg::X_W-1:0]      x_in,
    output logic                          eval_ack,
    output logic [plot_pkg::Y_W-1:0]      y_out,
    input  logic [plot_pkg::QLEN_W-1:0]   tok_count,
    output logic                          get_req,
    output logic [plot_pkg::QIDX_W-1:0]   get_index,
    input  logic                          get_ack,
    input  plot_pkg::token_t              get_data,
    output logic                          alu_req,
    output fxp_pkg::alu_op_e              alu_op,
    output fxp_pkg::fxp_t                 alu_a,
    output fxp_pkg::fxp_t                 alu_b,
    input  logic                          alu_ack,
    input  fxp_pkg::fxp_t                 alu_result
);

    localparam int SP_W = $clog2(plot_pkg::STACK_SIZE);

    typedef enum logic [3:0] {
        S_IDLE,
        S_X_DIV,
        S_X_SAVE,
        S_FETCH,
        S_GET_WAIT,
        S_GET_DROP,
        S_OP_SAVE,
        S_Y_MUL,
        S_Y_SUB,
        S_Y_SAVE,
        S_ALU_WAIT,
        S_ALU_DROP,
        S_DONE
    } state_e;

    state_e                       state;
    state_e                       ret;
    fxp_pkg::fxp_t                x_val;
    fxp_pkg::fxp_t                alu_val;
    plot_pkg::token_t             tok;
    logic [plot_pkg::QLEN_W-1:0]  tok_pos;
    fxp_pkg::fxp_t                stack [plot_pkg::STACK_SIZE];
    logic [SP_W-1:0]              sp;

    assign get_index = tok_pos[plot_pkg::QIDX_W-1:0];

    function automatic fxp_pkg::fxp_t int_to_fxp(input int v);
        return fxp_pkg::fxp_t'(v << fxp_pkg::FRAC_W);
    endfunction

    // start an ALU request, resume at next once ack has dropped
    task automatic alu_issue(input fxp_pkg::alu_op_e op,
                             input fxp_pkg::fxp_t    a,
                             input fxp_pkg::fxp_t    b,
                             input state_e           next);
        alu_op  <= op;
        alu_a   <= a;
        alu_b   <= b;
        alu_req <= 1'b1;
        ret     <= next;
        state   <= S_ALU_WAIT;
    endtask

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            eval_ack <= 1'b0;
            get_req  <= 1'b0;
            alu_req  <= 1'b0;
            tok_pos  <= '0;
            sp       <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (eval_req) begin
                        tok_pos <= '0;
                        sp      <= '0;
                        // x - 320 first
                        alu_issue(fxp_pkg::OP_SUB,
                                  fxp_pkg::fxp_t'({x_in, {fxp_pkg::FRAC_W{1'b0}}}),
                                  int_to_fxp(plot_pkg::H_PIXELS / 2), S_X_DIV);
                    end
                end
                S_X_DIV: begin
                    alu_issue(fxp_pkg::OP_DIV, alu_val,
                              int_to_fxp(plot_pkg::PLOT_SCALE), S_X_SAVE);
                end
                S_X_SAVE: begin
                    x_val <= alu_val;
                    state <= S_FETCH;
                end
                S_FETCH: begin
                    if (tok_pos >= tok_count) begin
                        state <= S_Y_MUL;
                    end else begin
                        get_req <= 1'b1;
                        state   <= S_GET_WAIT;
                    end
                end
                S_GET_WAIT: begin
                    if (get_ack) begin
                        tok     <= get_data;
                        get_req <= 1'b0;
                        tok_pos <= tok_pos + 1'b1;
                        state   <= S_GET_DROP;
                    end
                end
                S_GET_DROP: begin
                    // decode once the queue has released the port
                    if (!get_ack) begin
                        if (!tok[plot_pkg::TOK_W-1]) begin
                            stack[sp] <= fxp_pkg::fxp_t'(tok[fxp_pkg::NUM_W-1:0]);
                            sp        <= sp + 1'b1;
                            state     <= S_FETCH;
                        end else if (tok[2:0] == 3'(plot_pkg::TOK_VAR)) begin
                            stack[sp] <= x_val;
                            sp        <= sp + 1'b1;
                            state     <= S_FETCH;
                        end else begin
                            alu_issue(fxp_pkg::alu_op_e'(tok[2:0]), stack[sp - 2'd2],
                                      stack[sp - 1'b1], S_OP_SAVE);
                        end
                    end
                end
                S_OP_SAVE: begin
                    stack[sp - 2'd2] <= alu_val;
                    sp               <= sp - 1'b1;
                    state            <= S_FETCH;
                end
                S_Y_MUL: begin
                    alu_issue(fxp_pkg::OP_MUL, stack[0],
                              int_to_fxp(plot_pkg::PLOT_SCALE), S_Y_SUB);
                end
                S_Y_SUB: begin
                    alu_issue(fxp_pkg::OP_SUB, int_to_fxp(plot_pkg::V_PIXELS / 2),
                              alu_val, S_Y_SAVE);
                end
                S_Y_SAVE: begin
                    y_out    <= alu_val[fxp_pkg::FRAC_W +: plot_pkg::Y_W];
                    eval_ack <= 1'b1;
                    state    <= S_DONE;
                end
                S_ALU_WAIT: begin
                    if (alu_ack) begin
                        alu_val <= alu_result;
                        alu_req <= 1'b0;
                        state   <= S_ALU_DROP;
                    end
                end
                S_ALU_DROP: begin
                    if (!alu_ack) begin
                        state <= ret;
                    end
                end
                S_DONE: begin
                    if (!eval_req) begin
                        eval_ack <= 1'b0;
                        state    <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

/* rpn_queue.sv */
`timescale 1ns/1ps

module rpn_queue (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          tok_clear,
    input  logic                          tok_wr,
    input  plot_pkg::token_t              tok_data,
    output logic [plot_pkg::QLEN_W-1:0]   tok_count,
    input  logic                          get_req,
    input  logic [plot_pkg::QIDX_W-1:0]   get_index,
    output logic                          get_ack,
    output plot_pkg::token_t              get_data
);

    plot_pkg::token_t mem [plot_pkg::QUEUE_SIZE];
    logic             wr_ok;

    // writes to a full queue are dropped
    assign wr_ok = tok_wr && !tok_clear && (tok_count < plot_pkg::QUEUE_SIZE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tok_count <= '0;
        end else if (tok_clear) begin
            tok_count <= '0;
        end else if (wr_ok) begin
            tok_count <= tok_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[tok_count[plot_pkg::QIDX_W-1:0]] <= tok_data;
        end
    end

    // read port, token held until the request drops
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            get_ack <= 1'b0;
        end else if (get_req && !get_ack) begin
            get_ack <= 1'b1;
        end else if (!get_req) begin
            get_ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (get_req && !get_ack) begin
            get_data <= mem[get_index];
        end
    end

endmodule

/* fixed_point_alu.sv */
`timescale 1ns/1ps

module fixed_point_alu (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             alu_req,
    input  fxp_pkg::alu_op_e alu_op,
    input  fxp_pkg::fxp_t    alu_a,
    input  fxp_pkg::fxp_t    alu_b,
    output logic             alu_ack,
    output fxp_pkg::fxp_t    alu_result
);

    // dividend is |a| shifted up by the fraction width
    localparam int DIV_BITS = fxp_pkg::NUM_W + fxp_pkg::FRAC_W;
    localparam int ACC_W    = fxp_pkg::NUM_W + 1 + DIV_BITS;

    typedef enum logic [1:0] {
        S_IDLE,
        S_CALC,
        S_HOLD
    } state_e;

    state_e                              state;
    fxp_pkg::alu_op_e                    op_q;
    fxp_pkg::fxp_t                       base;
    logic [4:0]                          cnt;
    logic [ACC_W-1:0]                    div_acc;
    logic [ACC_W-1:0]                    div_once;
    logic [ACC_W-1:0]                    div_next;
    logic [fxp_pkg::NUM_W-1:0]           div_dvs;
    logic [fxp_pkg::NUM_W-1:0]           div_q;
    logic                                div_neg;
    logic [fxp_pkg::NUM_W-1:0]           mag_a;
    logic [fxp_pkg::NUM_W-1:0]           mag_b;
    fxp_pkg::fxp_t                       mul_x;
    fxp_pkg::fxp_t                       mul_y;
    fxp_pkg::fxp_t                       mul_res;
    logic signed [2*fxp_pkg::NUM_W-1:0]  product;
    fxp_pkg::fxp_t                       pow_int;
    logic [4:0]                          pow_n;

    // one restoring shift-subtract step
    function automatic logic [ACC_W-1:0] div_step(input logic [ACC_W-1:0]          acc_in,
                                                  input logic [fxp_pkg::NUM_W-1:0] dvs);
        logic [ACC_W-1:0]          acc;
        logic [fxp_pkg::NUM_W:0]   rem;
        acc = acc_in << 1;
        rem = acc[ACC_W-1:DIV_BITS];
        if (rem >= {1'b0, dvs}) begin
            acc[ACC_W-1:DIV_BITS] = rem - {1'b0, dvs};
            acc[0]                = 1'b1;
        end
        return acc;
    endfunction

    // shared multiplier, power loop reuses it on the running result
    assign mul_x   = (state == S_CALC) ? alu_result : alu_a;
    assign mul_y   = (state == S_CALC) ? base : alu_b;
    assign product = mul_x * mul_y;
    assign mul_res = product[fxp_pkg::FRAC_W +: fxp_pkg::NUM_W];

    assign mag_a = alu_a[fxp_pkg::NUM_W-1] ? -alu_a : alu_a;
    assign mag_b = alu_b[fxp_pkg::NUM_W-1] ? -alu_b : alu_b;

    // first FRAC_W cycles retire two quotient bits each
    assign div_once = div_step(div_acc, div_dvs);
    assign div_next = (cnt < fxp_pkg::FRAC_W) ? div_step(div_once, div_dvs) : div_once;
    assign div_q    = div_next[fxp_pkg::NUM_W-1:0];

    // floor of b, clamped
    assign pow_int = alu_b >>> fxp_pkg::FRAC_W;

    always_comb begin
        if (pow_int <= 0) begin
            pow_n = '0;
        end else if (pow_int > fxp_pkg::POW_MAX_EXP) begin
            pow_n = 5'(fxp_pkg::POW_MAX_EXP);
        end else begin
            pow_n = pow_int[4:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            alu_ack <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (alu_req) begin
                        op_q  <= alu_op;
                        base  <= alu_a;
                        cnt   <= '0;
                        state <= S_HOLD;
                        alu_ack <= 1'b1;
                        case (alu_op)
                            fxp_pkg::OP_ADD: alu_result <= alu_a + alu_b;
                            fxp_pkg::OP_SUB: alu_result <= alu_a - alu_b;
                            fxp_pkg::OP_MUL: alu_result <= mul_res;
                            fxp_pkg::OP_DIV: begin
                                if (alu_b == '0) begin
                                    alu_result <= alu_a[fxp_pkg::NUM_W-1] ?
                                                  fxp_pkg::FXP_MIN : fxp_pkg::FXP_MAX;
                                end else begin
                                    div_acc <= {{(fxp_pkg::NUM_W+1){1'b0}}, mag_a,
                                                {fxp_pkg::FRAC_W{1'b0}}};
                                    div_dvs <= mag_b;
                                    div_neg <= alu_a[fxp_pkg::NUM_W-1] ^
                                               alu_b[fxp_pkg::NUM_W-1];
                                    state   <= S_CALC;
                                    alu_ack <= 1'b0;
                                end
                            end
                            fxp_pkg::OP_POW: begin
                                if (pow_n == '0) begin
                                    alu_result <= fxp_pkg::FXP_ONE;
                                end else begin
                                    alu_result <= alu_a;
                                    cnt        <= pow_n - 5'd1;
                                    if (pow_n != 5'd1) begin
                                        state   <= S_CALC;
                                        alu_ack <= 1'b0;
                                    end
                                end
                            end
                            default: alu_result <= '0;
                        endcase
                    end
                end
                S_CALC: begin
                    if (op_q == fxp_pkg::OP_DIV) begin
                        div_acc <= div_next;
                        cnt     <= cnt + 5'd1;
                        if (cnt == 5'(fxp_pkg::NUM_W - 1)) begin
                            alu_result <= div_neg ? -div_q : div_q;
                            alu_ack    <= 1'b1;
                            state      <= S_HOLD;
                        end
                    end else begin
                        alu_result <= mul_res;
                        cnt        <= cnt - 5'd1;
                        if (cnt == 5'd1) begin
                            alu_ack <= 1'b1;
                            state   <= S_HOLD;
                        end
                    end
                end
                S_HOLD: begin
                    if (!alu_req) begin
                        alu_ack <= 1'b0;
                        state   <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

/* plot_pkg.sv */
package plot_pkg;

    // active screen area
    localparam int H_PIXELS = 640;
    localparam int V_PIXELS = 480;

    localparam int X_W = 10;
    localparam int Y_W = 9;

    // pixels per plot unit
    localparam int PLOT_SCALE = 20;

    // token memory
    localparam int QUEUE_SIZE = 64;
    localparam int QIDX_W     = 6;
    localparam int QLEN_W     = 7;

    localparam int STACK_SIZE = 16;

    // msb set means operator, payload below
    localparam int TOK_W = fxp_pkg::NUM_W + 1;

    typedef logic [TOK_W-1:0] token_t;

    // operator code that pushes x
    localparam int TOK_VAR = 6;

endpackage

/* fxp_pkg.sv */
package fxp_pkg;

    // signed Q12.8
    localparam int INT_W  = 12;
    localparam int FRAC_W = 8;
    localparam int NUM_W  = INT_W + FRAC_W;

    typedef logic signed [NUM_W-1:0] fxp_t;

    // divide by zero saturates to these
    localparam fxp_t FXP_MAX = {1'b0, {(NUM_W-1){1'b1}}};
    localparam fxp_t FXP_MIN = {1'b1, {(NUM_W-1){1'b0}}};

    localparam fxp_t FXP_ONE = fxp_t'(1 << FRAC_W);

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_MUL = 3'd2,
        OP_DIV = 3'd3,
        OP_POW = 3'd4
    } alu_op_e;

    // exponent clamp for the power unit
    localparam int POW_MAX_EXP = 15;

endpackage
